// ==== axi_sram/axi_sram_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_sram_ctrl (
    input  wire                           ACLK,
    input  wire                           ARESETn,
    input  wire  [axi_pkg::ID_W-1:0]      awid,
    input  wire  [axi_pkg::ADDR_W-1:0]    awaddr,
    input  wire  [axi_pkg::LEN_W-1:0]     awlen,
    input  wire  [axi_pkg::SIZE_W-1:0]    awsize,
    input  wire  [1:0]                    awburst,   // ignored, every burst runs as INCR
    input  wire                           awvalid,
    output logic                          awready,
    input  wire  [axi_pkg::DATA_W-1:0]    wdata,
    input  wire  [axi_pkg::STRB_W-1:0]    wstrb,
    input  wire                           wlast,     // burst end comes from the counter
    input  wire                           wvalid,
    output logic                          wready,
    output logic [axi_pkg::ID_W-1:0]      bid,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  wire                           bready,
    input  wire  [axi_pkg::ID_W-1:0]      arid,
    input  wire  [axi_pkg::ADDR_W-1:0]    araddr,
    input  wire  [axi_pkg::LEN_W-1:0]     arlen,
    input  wire  [axi_pkg::SIZE_W-1:0]    arsize,
    input  wire  [1:0]                    arburst,   // ignored as well
    input  wire                           arvalid,
    output logic                          arready,
    output logic [axi_pkg::ID_W-1:0]      rid,
    output logic [axi_pkg::DATA_W-1:0]    rdata,
    output logic [1:0]                    rresp,
    output logic                          rlast,
    output logic                          rvalid,
    input  wire                           rready,
    input  wire  [axi_pkg::ADDR_W-1:0]    beat_addr,
    input  wire                           beat_last,
    input  wire  [axi_pkg::DATA_W-1:0]    mem_rdata,
    output logic                          cnt_load,
    output logic                          cnt_step,
    output logic [axi_pkg::ADDR_W-1:0]    start_addr,
    output logic [axi_pkg::SIZE_W-1:0]    start_size,
    output logic [axi_pkg::LEN_W-1:0]     start_len,
    output logic                          mem_en,
    output logic [axi_pkg::STRB_W-1:0]    mem_we,
    output logic [sram_pkg::WORD_ADDR_W-1:0] mem_addr,
    output logic [axi_pkg::DATA_W-1:0]    mem_wdata
);

    typedef enum logic [2:0] {IDLE, WDATA, BRESP, RREQ, RDATA, RWAIT} state_t;

    state_t                      state;
    state_t                      state_nxt;
    logic [axi_pkg::ID_W-1:0]    id_q;
    axi_pkg::resp_t              resp_q;
    logic [axi_pkg::DATA_W-1:0]  rdata_q;
    logic                        aw_hs;
    logic                        ar_hs;
    logic                        w_hs;
    logic                        b_hs;
    logic                        r_hs;
    logic                        acc_ok;

    // size check first, address range only for legal sizes
    function automatic axi_pkg::resp_t decide_resp(
        input logic [axi_pkg::ADDR_W-1:0] addr,
        input logic [axi_pkg::SIZE_W-1:0] size
    );
        if (size > axi_pkg::MAX_SIZE) begin
            return axi_pkg::RESP_SLVERR;
        end
        if (addr >= sram_pkg::MEM_BYTES) begin
            return axi_pkg::RESP_DECERR;
        end
        return axi_pkg::RESP_OKAY;
    endfunction

    assign awready = (state == IDLE);
    assign arready = (state == IDLE) && !awvalid;   // write wins a tie
    assign wready  = (state == WDATA);
    assign bvalid  = (state == BRESP);
    assign rvalid  = (state == RWAIT);

    assign aw_hs  = awvalid && awready;
    assign ar_hs  = arvalid && arready;
    assign w_hs   = wvalid && wready;
    assign b_hs   = bvalid && bready;
    assign r_hs   = rvalid && rready;
    assign acc_ok = (resp_q == axi_pkg::RESP_OKAY);

    // burst setup for the counter, taken from whichever channel is granted
    assign start_addr = awvalid ? awaddr : araddr;
    assign start_size = awvalid ? awsize : arsize;
    assign start_len  = awvalid ? awlen : arlen;
    assign cnt_load   = aw_hs || ar_hs;
    assign cnt_step   = w_hs || r_hs;

    assign mem_addr  = beat_addr[sram_pkg::BYTE_OFS_W +: sram_pkg::WORD_ADDR_W];
    assign mem_wdata = wdata;
    assign mem_en    = acc_ok && (w_hs || (state == RREQ));
    assign mem_we    = (acc_ok && w_hs) ? wstrb : '0;   // errored beats write nothing

    assign bid   = id_q;
    assign rid   = id_q;
    assign bresp = resp_q;
    assign rresp = resp_q;
    assign rdata = rdata_q;
    assign rlast = rvalid && beat_last;   // counter is frozen while waiting

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (aw_hs) begin
                    state_nxt = WDATA;
                end else if (ar_hs) begin
                    state_nxt = RREQ;
                end
            end
            WDATA: begin
                if (w_hs && beat_last) begin
                    state_nxt = BRESP;
                end
            end
            BRESP: begin
                if (b_hs) begin
                    state_nxt = IDLE;
                end
            end
            RREQ:  state_nxt = RDATA;   // sram read issued this cycle
            RDATA: state_nxt = RWAIT;   // word captured at the end of this cycle
            RWAIT: begin
                if (r_hs) begin
                    state_nxt = beat_last ? IDLE : RREQ;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state  <= IDLE;
            resp_q <= axi_pkg::RESP_OKAY;
        end else begin
            state <= state_nxt;
            if (cnt_load) begin
                resp_q <= decide_resp(start_addr, start_size);
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (cnt_load) begin
            id_q <= aw_hs ? awid : arid;
        end
        if (state == RDATA) begin
            rdata_q <= acc_ok ? mem_rdata : '0;   // error beats carry zero data
        end
    end

endmodule

`default_nettype wire

// ==== axi_sram/axi_sram_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_sram_top (
    input  wire                          ACLK,
    input  wire                          ARESETn,
    input  wire  [axi_pkg::ID_W-1:0]     awid,
    input  wire  [axi_pkg::ADDR_W-1:0]   awaddr,
    input  wire  [axi_pkg::LEN_W-1:0]    awlen,
    input  wire  [axi_pkg::SIZE_W-1:0]   awsize,
    input  wire  [1:0]                   awburst,
    input  wire                          awvalid,
    output logic                         awready,
    input  wire  [axi_pkg::DATA_W-1:0]   wdata,
    input  wire  [axi_pkg::STRB_W-1:0]   wstrb,
    input  wire                          wlast,
    input  wire                          wvalid,
    output logic                         wready,
    output logic [axi_pkg::ID_W-1:0]     bid,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  wire                          bready,
    input  wire  [axi_pkg::ID_W-1:0]     arid,
    input  wire  [axi_pkg::ADDR_W-1:0]   araddr,
    input  wire  [axi_pkg::LEN_W-1:0]    arlen,
    input  wire  [axi_pkg::SIZE_W-1:0]   arsize,
    input  wire  [1:0]                   arburst,
    input  wire                          arvalid,
    output logic                         arready,
    output logic [axi_pkg::ID_W-1:0]     rid,
    output logic [axi_pkg::DATA_W-1:0]   rdata,
    output logic [1:0]                   rresp,
    output logic                         rlast,
    output logic                         rvalid,
    input  wire                          rready
);

    logic                             cnt_load;
    logic                             cnt_step;
    logic [axi_pkg::ADDR_W-1:0]       start_addr;
    logic [axi_pkg::SIZE_W-1:0]       start_size;
    logic [axi_pkg::LEN_W-1:0]        start_len;
    logic [axi_pkg::ADDR_W-1:0]       beat_addr;
    logic                             beat_last;
    logic                             mem_en;
    logic [axi_pkg::STRB_W-1:0]       mem_we;
    logic [sram_pkg::WORD_ADDR_W-1:0] mem_addr;
    logic [axi_pkg::DATA_W-1:0]       mem_wdata;
    logic [axi_pkg::DATA_W-1:0]       mem_rdata;

    axi_sram_ctrl i_ctrl (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .awid       (awid),
        .awaddr     (awaddr),
        .awlen      (awlen),
        .awsize     (awsize),
        .awburst    (awburst),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wlast      (wlast),
        .wvalid     (wvalid),
        .wready     (wready),
        .bid        (bid),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .arid       (arid),
        .araddr     (araddr),
        .arlen      (arlen),
        .arsize     (arsize),
        .arburst    (arburst),
        .arvalid    (arvalid),
        .arready    (arready),
        .rid        (rid),
        .rdata      (rdata),
        .rresp      (rresp),
        .rlast      (rlast),
        .rvalid     (rvalid),
        .rready     (rready),
        .beat_addr  (beat_addr),
        .beat_last  (beat_last),
        .mem_rdata  (mem_rdata),
        .cnt_load   (cnt_load),
        .cnt_step   (cnt_step),
        .start_addr (start_addr),
        .start_size (start_size),
        .start_len  (start_len),
        .mem_en     (mem_en),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    burst_addr_counter i_cnt (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .load       (cnt_load),
        .step       (cnt_step),
        .start_addr (start_addr),
        .start_size (start_size),
        .start_len  (start_len),
        .addr       (beat_addr),
        .last       (beat_last)
    );

    sram_model i_mem (
        .ACLK  (ACLK),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== axi_sram/burst_addr_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_addr_counter (
    input  wire                          ACLK,
    input  wire                          ARESETn,
    input  wire                          load,
    input  wire                          step,
    input  wire  [axi_pkg::ADDR_W-1:0]   start_addr,
    input  wire  [axi_pkg::SIZE_W-1:0]   start_size,
    input  wire  [axi_pkg::LEN_W-1:0]    start_len,
    output logic [axi_pkg::ADDR_W-1:0]   addr,
    output logic                         last
);

    logic [axi_pkg::SIZE_W-1:0]        size_q;
    logic [axi_pkg::LEN_W-1:0]         remain_q;   // beats left after the current one
    logic [sram_pkg::BYTE_ADDR_W-1:0]  beat_bytes;
    logic [sram_pkg::BYTE_ADDR_W-1:0]  ofs_nxt;

    assign beat_bytes = {{(sram_pkg::BYTE_ADDR_W-1){1'b0}}, 1'b1} << size_q;
    assign ofs_nxt    = addr[sram_pkg::BYTE_ADDR_W-1:0] + beat_bytes;   // wraps at 64 KiB
    assign last       = (remain_q == '0);

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            addr     <= '0;
            size_q   <= '0;
            remain_q <= '0;
        end else if (load) begin
            addr     <= start_addr;
            size_q   <= start_size;
            remain_q <= start_len;
        end else if (step) begin
            // upper bits stay, so an out-of-range burst keeps its region
            addr     <= {addr[axi_pkg::ADDR_W-1:sram_pkg::BYTE_ADDR_W], ofs_nxt};
            remain_q <= remain_q - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== common/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;   // one strobe per byte lane
    localparam int ID_W   = 8;
    localparam int LEN_W  = 8;            // beats minus one
    localparam int SIZE_W = 3;

    // bytes per beat is 2**size, so 2 means a full 32-bit word
    localparam logic [SIZE_W-1:0] MAX_SIZE = 3'd2;

    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

endpackage

`default_nettype wire

// ==== common/sram_pkg.sv ====
`default_nettype none

package sram_pkg;

    localparam int WORD_ADDR_W = 14;
    localparam int BYTE_OFS_W  = 2;                          // byte select inside a word
    localparam int BYTE_ADDR_W = WORD_ADDR_W + BYTE_OFS_W;   // byte address span of the array
    localparam int MEM_WORDS   = 1 << WORD_ADDR_W;
    localparam int MEM_BYTES   = MEM_WORDS << BYTE_OFS_W;    // 64 KiB

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_axi_sram -f sources.f \
    -o sim_axi_sram || { echo "build failed"; exit 1; }
./obj_dir/sim_axi_sram > sim.log 2>&1
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "no pass message in the log"; exit 1; }
echo "simulation passed"

// ==== source/sram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_model (
    input  wire                              ACLK,
    input  wire                              en,
    input  wire  [axi_pkg::STRB_W-1:0]       we,
    input  wire  [sram_pkg::WORD_ADDR_W-1:0] addr,
    input  wire  [axi_pkg::DATA_W-1:0]       wdata,
    output logic [axi_pkg::DATA_W-1:0]       rdata
);

    logic [axi_pkg::DATA_W-1:0] mem [sram_pkg::MEM_WORDS];

    // write when any lane is enabled, otherwise a registered read
    always_ff @(posedge ACLK) begin
        if (en) begin
            if (|we) begin
                for (int i = 0; i < axi_pkg::STRB_W; i++) begin
                    if (we[i]) begin
                        mem[addr][8*i +: 8] <= wdata[8*i +: 8];   // only strobed lanes
                    end
                end
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
common/axi_pkg.sv
common/sram_pkg.sv
source/sram_model.sv
axi_sram/burst_addr_counter.sv
axi_sram/axi_sram_ctrl.sv
axi_sram/axi_sram_top.sv
verif/axi_sram_props.sv
verif/tb_axi_sram.sv

// ==== verif/axi_sram_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_sram_props (
    input wire                         ACLK,
    input wire                         ARESETn,
    input wire                         awready,
    input wire                         arvalid,
    input wire                         arready,
    input wire                         wvalid,
    input wire                         wready,
    input wire                         wlast,
    input wire                         bvalid,
    input wire                         bready,
    input wire [axi_pkg::ID_W-1:0]     bid,
    input wire [1:0]                   bresp,
    input wire                         rvalid,
    input wire                         rready,
    input wire [axi_pkg::ID_W-1:0]     rid,
    input wire [axi_pkg::DATA_W-1:0]   rdata,
    input wire [1:0]                   rresp,
    input wire                         rlast
);

    // idle handshake outputs in reset and on the first edge after it
    assert property (@(posedge ACLK) (!ARESETn || $rose(ARESETn)) |->
                     awready && !wready && !bvalid && !rvalid)
        else $error("handshake outputs not idle around reset");

    assert property (@(posedge ACLK) disable iff (!ARESETn)
                     bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp))
        else $error("write response changed while stalled");

    assert property (@(posedge ACLK) disable iff (!ARESETn)
                     rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
                     && $stable(rid) && $stable(rlast))
        else $error("read beat changed while stalled");

    assert property (@(posedge ACLK) disable iff (!ARESETn)
                     wvalid && wready && wlast |=> bvalid)
        else $error("write response late after the last data beat");

    // request, capture, then the beat is offered
    assert property (@(posedge ACLK) disable iff (!ARESETn)
                     arvalid && arready |=> !rvalid ##1 !rvalid ##1 rvalid)
        else $error("first read beat not two cycles after the address");

    assert property (@(posedge ACLK) disable iff (!ARESETn)
                     rvalid && rready && !rlast |=> !rvalid ##1 !rvalid ##1 rvalid)
        else $error("next read beat not two cycles after the previous one");

endmodule

bind axi_sram_top axi_sram_props i_props (.*);

`default_nettype wire

// ==== verif/tb_axi_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_sram;

    localparam int TIMEOUT_CYCLES = 20000;   // ~60 bursts of up to 8 beats plus stalls
    localparam int N_ROUNDS       = 16;      // full write, strobed write, read back

    logic                         ACLK;
    logic                         ARESETn;
    logic [axi_pkg::ID_W-1:0]     awid;
    logic [axi_pkg::ADDR_W-1:0]   awaddr;
    logic [axi_pkg::LEN_W-1:0]    awlen;
    logic [axi_pkg::SIZE_W-1:0]   awsize;
    logic [1:0]                   awburst;
    logic                         awvalid;
    logic                         awready;
    logic [axi_pkg::DATA_W-1:0]   wdata;
    logic [axi_pkg::STRB_W-1:0]   wstrb;
    logic                         wlast;
    logic                         wvalid;
    logic                         wready;
    logic [axi_pkg::ID_W-1:0]     bid;
    logic [1:0]                   bresp;
    logic                         bvalid;
    logic                         bready;
    logic [axi_pkg::ID_W-1:0]     arid;
    logic [axi_pkg::ADDR_W-1:0]   araddr;
    logic [axi_pkg::LEN_W-1:0]    arlen;
    logic [axi_pkg::SIZE_W-1:0]   arsize;
    logic [1:0]                   arburst;
    logic                         arvalid;
    logic                         arready;
    logic [axi_pkg::ID_W-1:0]     rid;
    logic [axi_pkg::DATA_W-1:0]   rdata;
    logic [1:0]                   rresp;
    logic                         rlast;
    logic                         rvalid;
    logic                         rready;

    logic [7:0] ref_mem   [sram_pkg::MEM_BYTES];   // expected memory, byte wide
    bit         ref_known [sram_pkg::MEM_BYTES];   // bytes written so far
    int         cycles = 0;
    bit         pass_reached = 1'b0;
    bit         fail_shown = 1'b0;

    axi_sram_top i_axi_sram_top (.*);

    initial begin
        ACLK = 1'b0;
        forever #20 ACLK = ~ACLK;
    end

    always @(posedge ACLK) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            fail_stop();
        end
    end

    task automatic fail_stop();
        fail_shown = 1'b1;
        $display(">>> FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            fail_stop();
        end
    endtask

    function automatic logic [31:0] rand_word_addr();
        return 32'($urandom_range(sram_pkg::MEM_WORDS - 1, 0)) << 2;
    endfunction

    // word base of a beat, addresses wrap at the end of the memory
    function automatic int lane_base(input logic [31:0] addr, input int beat,
                                     input logic [2:0] size);
        logic [31:0] byte_addr;
        byte_addr = addr + (32'(beat) << size);
        return int'(byte_addr % sram_pkg::MEM_BYTES) & ~3;
    endfunction

    task automatic write_burst(input logic [7:0] id, input logic [31:0] addr,
                               input logic [7:0] len, input logic [2:0] size,
                               input bit partial, input axi_pkg::resp_t exp_resp);
        logic [31:0] data;
        logic [3:0]  strb;
        int          base;
        bit          done;
        awid    = id;
        awaddr  = addr;
        awlen   = len;
        awsize  = size;
        awburst = 2'b01;
        awvalid = 1'b1;
        do begin
            @(negedge ACLK);
            done = awready;
            @(posedge ACLK);
            #2;
        end while (!done);
        awvalid = 1'b0;
        for (int beat = 0; beat <= len; beat++) begin
            wvalid = 1'b0;
            if ($urandom_range(3, 0) == 0) begin
                @(posedge ACLK);   // idle cycle on W
                #2;
            end
            data   = $urandom();
            strb   = partial ? 4'($urandom()) : 4'hf;
            wdata  = data;
            wstrb  = strb;
            wlast  = (beat == len);
            wvalid = 1'b1;
            do begin
                @(negedge ACLK);
                done = wready;
                @(posedge ACLK);
                #2;
            end while (!done);
            if (exp_resp == axi_pkg::RESP_OKAY) begin
                base = lane_base(addr, beat, size);
                for (int i = 0; i < axi_pkg::STRB_W; i++) begin
                    if (strb[i]) begin
                        ref_mem[base + i]   = data[8*i +: 8];
                        ref_known[base + i] = 1'b1;
                    end
                end
            end
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        done   = 1'b0;
        while (!done) begin
            bready = ($urandom_range(2, 0) != 0);   // stall about a third of the time
            @(negedge ACLK);
            if (bvalid && bready) begin
                check_eq("bid", bid, id);
                check_eq("bresp", bresp, exp_resp);
                done = 1'b1;
            end
            @(posedge ACLK);
            #2;
        end
        bready = 1'b0;
    endtask

    task automatic read_burst(input logic [7:0] id, input logic [31:0] addr,
                              input logic [7:0] len, input logic [2:0] size,
                              input axi_pkg::resp_t exp_resp);
        logic [31:0] mask;
        logic [31:0] exp;
        int          base;
        int          beat;
        bit          done;
        arid    = id;
        araddr  = addr;
        arlen   = len;
        arsize  = size;
        arburst = 2'b01;
        arvalid = 1'b1;
        do begin
            @(negedge ACLK);
            done = arready;
            @(posedge ACLK);
            #2;
        end while (!done);
        arvalid = 1'b0;
        beat    = 0;
        done    = 1'b0;
        while (!done) begin
            rready = ($urandom_range(2, 0) != 0);
            @(negedge ACLK);
            if (rvalid && rready) begin
                check_eq("rid", rid, id);
                check_eq("rresp", rresp, exp_resp);
                check_eq("rlast", rlast, beat == len);
                if (exp_resp == axi_pkg::RESP_OKAY) begin
                    base = lane_base(addr, beat, size);
                    mask = '0;
                    exp  = '0;
                    for (int i = 0; i < axi_pkg::STRB_W; i++) begin
                        if (ref_known[base + i]) begin
                            mask[8*i +: 8] = 8'hff;
                            exp[8*i +: 8]  = ref_mem[base + i];
                        end
                    end
                    check_eq("rdata", rdata & mask, exp);
                end else begin
                    check_eq("rdata", rdata, 32'h0);   // error beats carry no data
                end
                done = (beat == len);
                beat++;
            end
            @(posedge ACLK);
            #2;
        end
        rready = 1'b0;
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] base_addr;
        logic [7:0]  len;
        logic [7:0]  base_len;
        void'($urandom(72));
        ARESETn = 1'b0;
        awid    = '0;
        awaddr  = '0;
        awlen   = '0;
        awsize  = '0;
        awburst = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wlast   = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        arid    = '0;
        araddr  = '0;
        arlen   = '0;
        arsize  = '0;
        arburst = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (5) @(posedge ACLK);
        #2;
        ARESETn = 1'b1;
        @(negedge ACLK);
        check_eq("awready", awready, 1'b1);
        check_eq("arready", arready, 1'b1);
        @(posedge ACLK);
        #2;

        for (int n = 0; n < N_ROUNDS; n++) begin
            addr = (n == 1) ? sram_pkg::MEM_BYTES - 8 : rand_word_addr();   // round 1 wraps
            len  = (n == 1) ? 8'd7 : 8'($urandom_range(7, 0));
            if (n == 0) begin
                base_addr = addr;
                base_len  = len;
            end
            write_burst(8'(n), addr, len, 3'd2, 1'b0, axi_pkg::RESP_OKAY);
            write_burst(8'(n + 64), addr, len, 3'd2, 1'b1, axi_pkg::RESP_OKAY);
            read_burst(8'(n + 128), addr, len, 3'd2, axi_pkg::RESP_OKAY);
        end

        // oversized beats, then a start address past the memory
        write_burst(8'ha1, base_addr, base_len, 3'd3, 1'b0, axi_pkg::RESP_SLVERR);
        read_burst(8'ha2, base_addr, base_len, 3'd3, axi_pkg::RESP_SLVERR);
        write_burst(8'ha3, base_addr + sram_pkg::MEM_BYTES, base_len, 3'd2, 1'b0,
                    axi_pkg::RESP_DECERR);
        read_burst(8'ha4, base_addr + sram_pkg::MEM_BYTES, base_len, 3'd2,
                   axi_pkg::RESP_DECERR);
        read_burst(8'ha5, base_addr, base_len, 3'd2, axi_pkg::RESP_OKAY);

        // AW and AR raised together on one region
        addr = rand_word_addr();
        len  = 8'($urandom_range(7, 0));
        fork
            write_burst(8'hc1, addr, len, 3'd2, 1'b0, axi_pkg::RESP_OKAY);
            read_burst(8'hc2, addr, len, 3'd2, axi_pkg::RESP_OKAY);
            begin
                @(negedge ACLK);
                check_eq("arready", arready, 1'b0);   // held off by awvalid
            end
        join

        repeat (4) @(posedge ACLK);
        if (!fail_shown) begin
            pass_reached = 1'b1;
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // a stop raised by a bound property ends up here
    final begin
        if (!pass_reached && !fail_shown) begin
            $display(">>> FAIL");
        end
    end

endmodule

`default_nettype wire
